/* include/riscv151_config.svh */
`ifndef RISCV151_CONFIG_SVH
`define RISCV151_CONFIG_SVH

// data path and register file sizes
`define XLEN      32
`define REG_AW    5
`define REG_COUNT 32

// major opcodes handled by decode
`define OPC_OP     7'b0110011  // register-register alu
`define OPC_OP_IMM 7'b0010011  // register-immediate alu
`define OPC_LUI    7'b0110111

`endif

/* src/riscv151_pkg.sv */
`default_nettype none

`include "riscv151_config.svh"

package riscv151_pkg;

    // alu functions, shared by decode and execute
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    // id/ex entry
    typedef struct packed {
        logic               valid;
        logic               illegal;   // strobed word that decode rejected
        logic [`REG_AW-1:0] rd;
        logic [`REG_AW-1:0] rs1;       // zero when the form has no rs1
        logic [`REG_AW-1:0] rs2;       // zero for immediate forms
        logic [`XLEN-1:0]   rs1_data;
        logic [`XLEN-1:0]   rs2_data;
        logic [`XLEN-1:0]   imm;
        logic               use_imm;
        logic               is_lui;
        alu_op_e            alu_op;
    } decoded_t;

    // ex/wb entry, also the register write request
    typedef struct packed {
        logic               valid;
        logic               illegal;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
    } retire_t;

endpackage

`default_nettype wire

/* src/inst_decode.sv */
`default_nettype none
`timescale 1ns/10ps

`include "riscv151_config.svh"

module inst_decode (
    input  logic                   inst_valid_i,
    input  logic [`XLEN-1:0]       inst_i,
    input  logic [`XLEN-1:0]       rs1_data_i,
    input  logic [`XLEN-1:0]       rs2_data_i,
    output logic [`REG_AW-1:0]     rs1_addr_o,
    output logic [`REG_AW-1:0]     rs2_addr_o,
    output riscv151_pkg::decoded_t entry_o
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic                  alt;       // inst bit 30
    logic                  legal;
    logic                  use_imm;
    logic                  is_lui;
    logic [`XLEN-1:0]      imm;
    logic [`REG_AW-1:0]    rs1;
    logic [`REG_AW-1:0]    rs2;
    riscv151_pkg::alu_op_e base_op;
    riscv151_pkg::alu_op_e alu_op;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign alt    = inst_i[30];

    // funct3 to alu function, bit 30 picks sub/sra
    always_comb begin
        case (funct3)
            3'b000:  base_op = alt ? riscv151_pkg::alu_sub : riscv151_pkg::alu_add;
            3'b001:  base_op = riscv151_pkg::alu_sll;
            3'b010:  base_op = riscv151_pkg::alu_slt;
            3'b011:  base_op = riscv151_pkg::alu_sltu;
            3'b100:  base_op = riscv151_pkg::alu_xor;
            3'b101:  base_op = alt ? riscv151_pkg::alu_sra : riscv151_pkg::alu_srl;
            3'b110:  base_op = riscv151_pkg::alu_or;
            default: base_op = riscv151_pkg::alu_and;
        endcase
    end

    always_comb begin
        legal   = 1'b0;
        use_imm = 1'b0;
        is_lui  = 1'b0;
        imm     = '0;
        rs1     = inst_i[19:15];
        rs2     = inst_i[24:20];
        alu_op  = base_op;
        case (opcode)
            `OPC_OP: begin
                // only sub and sra use the alternate funct7
                legal = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            `OPC_OP_IMM: begin
                use_imm = 1'b1;
                rs2     = '0;
                imm     = {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};
                case (funct3)
                    3'b001:  legal = (funct7 == 7'b0000000);   // slli
                    3'b101:  legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    default: legal = 1'b1;
                endcase
                if (funct3 == 3'b000) begin
                    alu_op = riscv151_pkg::alu_add;  // bit 30 is immediate data here
                end
            end
            `OPC_LUI: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                is_lui  = 1'b1;
                rs1     = '0;
                rs2     = '0;
                imm     = {inst_i[31:12], 12'b0};
            end
            default: legal = 1'b0;  // unsupported opcode
        endcase
    end

    assign rs1_addr_o = rs1;
    assign rs2_addr_o = rs2;

    always_comb begin
        entry_o.valid    = inst_valid_i && legal;
        entry_o.illegal  = inst_valid_i && !legal;
        entry_o.rd       = inst_i[11:7];
        entry_o.rs1      = rs1;
        entry_o.rs2      = rs2;
        entry_o.rs1_data = rs1_data_i;
        entry_o.rs2_data = rs2_data_i;
        entry_o.imm      = imm;
        entry_o.use_imm  = use_imm;
        entry_o.is_lui   = is_lui;
        entry_o.alu_op   = alu_op;
    end

endmodule

`default_nettype wire

/* src/regfile_1w2r.sv */
`default_nettype none
`timescale 1ns/10ps

`include "riscv151_config.svh"

module regfile_1w2r (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               we_i,
    input  logic [`REG_AW-1:0] waddr_i,
    input  logic [`XLEN-1:0]   wdata_i,
    input  logic [`REG_AW-1:0] raddr1_i,
    input  logic [`REG_AW-1:0] raddr2_i,
    output logic [`XLEN-1:0]   rdata1_o,
    output logic [`XLEN-1:0]   rdata2_o
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin  // x0 stays zero
            regs[waddr_i] <= wdata_i;
        end
    end

    // asynchronous reads
    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

    assert property (@(posedge clk) disable iff (reset_i) we_i |-> !$isunknown(waddr_i));

endmodule

`default_nettype wire

/* src/pipe_reg.sv */
`default_nettype none
`timescale 1ns/10ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // all-zero payload means every valid bit is low
    always_ff @(posedge clk) begin
        if (reset_i) begin
            q_o <= '0;
        end else begin
            q_o <= d_i;
        end
    end

    // first captured entry after reset must be fully known
    assert property (@(posedge clk) $fell(reset_i) |=> !$isunknown(q_o));

endmodule

`default_nettype wire

/* src/alu_exec.sv */
`default_nettype none
`timescale 1ns/10ps

`include "riscv151_config.svh"

module alu_exec (
    input  riscv151_pkg::decoded_t entry_i,
    input  riscv151_pkg::retire_t  prev_i,
    output riscv151_pkg::retire_t  result_o
);

    logic             fwd_rs1;
    logic             fwd_rs2;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_out;

    // predecessor in ex/wb has not reached the register file read yet
    assign fwd_rs1 = prev_i.valid && (prev_i.rd != '0) && (prev_i.rd == entry_i.rs1);
    assign fwd_rs2 = prev_i.valid && (prev_i.rd != '0) && (prev_i.rd == entry_i.rs2);

    assign op_a    = fwd_rs1 ? prev_i.data : entry_i.rs1_data;
    assign rs2_val = fwd_rs2 ? prev_i.data : entry_i.rs2_data;
    assign op_b    = entry_i.use_imm ? entry_i.imm : rs2_val;
    assign shamt   = op_b[4:0];  // low five bits only

    always_comb begin
        case (entry_i.alu_op)
            riscv151_pkg::alu_add:  alu_out = op_a + op_b;
            riscv151_pkg::alu_sub:  alu_out = op_a - op_b;
            riscv151_pkg::alu_sll:  alu_out = op_a << shamt;
            riscv151_pkg::alu_slt: begin
                alu_out = {{(`XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            riscv151_pkg::alu_sltu: alu_out = {{(`XLEN-1){1'b0}}, (op_a < op_b)};
            riscv151_pkg::alu_xor:  alu_out = op_a ^ op_b;
            riscv151_pkg::alu_srl:  alu_out = op_a >> shamt;
            riscv151_pkg::alu_sra:  alu_out = $unsigned($signed(op_a) >>> shamt);
            riscv151_pkg::alu_or:   alu_out = op_a | op_b;
            riscv151_pkg::alu_and:  alu_out = op_a & op_b;
            default:                alu_out = '0;
        endcase
    end

    always_comb begin
        result_o.valid   = entry_i.valid;
        result_o.illegal = entry_i.illegal;
        result_o.rd      = entry_i.rd;
        if (!entry_i.valid) begin
            result_o.data = '0;  // bubbles and illegal words carry no data
        end else if (entry_i.is_lui) begin
            result_o.data = entry_i.imm;
        end else begin
            result_o.data = alu_out;
        end
    end

endmodule

`default_nettype wire

/* src/riscv151.sv */
`default_nettype none
`timescale 1ns/10ps

`include "riscv151_config.svh"

module riscv151 (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               inst_valid_i,
    input  logic [`XLEN-1:0]   inst_i,
    output logic               retire_valid_o,
    output logic               retire_illegal_o,
    output logic [`REG_AW-1:0] retire_rd_o,
    output logic [`XLEN-1:0]   retire_data_o
);

    logic [`REG_AW-1:0]     rs1_addr;
    logic [`REG_AW-1:0]     rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    riscv151_pkg::decoded_t dec_entry;
    riscv151_pkg::decoded_t ex_entry;
    riscv151_pkg::retire_t  ex_result;
    riscv151_pkg::retire_t  wb_entry;

    inst_decode u_decode (
        .inst_valid_i(inst_valid_i),
        .inst_i      (inst_i),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .entry_o     (dec_entry)
    );

    // written from the ex result, so the next decode sees it
    regfile_1w2r u_rf (
        .clk     (clk),
        .reset_i (reset_i),
        .we_i    (ex_result.valid),
        .waddr_i (ex_result.rd),
        .wdata_i (ex_result.data),
        .raddr1_i(rs1_addr),
        .raddr2_i(rs2_addr),
        .rdata1_o(rs1_data),
        .rdata2_o(rs2_data)
    );

    pipe_reg #(.payload_t(riscv151_pkg::decoded_t)) id_ex (
        .clk    (clk),
        .reset_i(reset_i),
        .d_i    (dec_entry),
        .q_o    (ex_entry)
    );

    alu_exec u_exec (
        .entry_i (ex_entry),
        .prev_i  (wb_entry),   // forwarding source
        .result_o(ex_result)
    );

    pipe_reg #(.payload_t(riscv151_pkg::retire_t)) ex_wb (
        .clk    (clk),
        .reset_i(reset_i),
        .d_i    (ex_result),
        .q_o    (wb_entry)
    );

    assign retire_valid_o   = wb_entry.valid;
    assign retire_illegal_o = wb_entry.illegal;
    assign retire_rd_o      = wb_entry.rd;
    assign retire_data_o    = wb_entry.data;

endmodule

`default_nettype wire

/* verification/riscv151_tb.sv */
`default_nettype none
`timescale 1ns/10ps

`include "riscv151_config.svh"

module riscv151_tb;

    localparam int CLK_PERIOD = 8;
    localparam int RND        = -1;  // gap picked at random, 0 to 2 cycles

    logic               clk;
    logic               reset_i;
    logic               inst_valid_i;
    logic [`XLEN-1:0]   inst_i;
    logic               retire_valid_o;
    logic               retire_illegal_o;
    logic [`REG_AW-1:0] retire_rd_o;
    logic [`XLEN-1:0]   retire_data_o;

    string                 row_name[$];
    logic [`XLEN-1:0]      row_inst[$];
    int                    row_gap[$];  // idle cycles before the row
    riscv151_pkg::retire_t row_exp[$];
    int                    pending[$];  // rows sent, not yet retired

    riscv151 i_riscv151 (
        .clk             (clk),
        .reset_i         (reset_i),
        .inst_valid_i    (inst_valid_i),
        .inst_i          (inst_i),
        .retire_valid_o  (retire_valid_o),
        .retire_illegal_o(retire_illegal_o),
        .retire_rd_o     (retire_rd_o),
        .retire_data_o   (retire_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                           input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input int rs1,
                                           input logic [2:0] f3, input int rd);
        return {imm, 5'(rs1), f3, 5'(rd), 7'b0010011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input int rd);
        return {imm, 5'(rd), 7'b0110111};
    endfunction

    // ok low means the word must retire as illegal with no data
    task automatic add_row(input string name, input logic [31:0] inst, input int gap,
                           input logic ok, input int rd, input logic [31:0] data);
        riscv151_pkg::retire_t e;
        e.valid   = ok;
        e.illegal = !ok;
        e.rd      = 5'(rd);
        e.data    = ok ? data : '0;
        row_name.push_back(name);
        row_inst.push_back(inst);
        row_gap.push_back(gap);
        row_exp.push_back(e);
    endtask

    // fields shown as valid/illegal/rd/data
    task automatic check_retire(input string name, input riscv151_pkg::retire_t exp,
                                input riscv151_pkg::retire_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %b/%b/x%0d/%h actual %b/%b/x%0d/%h", name,
                     exp.valid, exp.illegal, exp.rd, exp.data,
                     act.valid, act.illegal, act.rd, act.data);
            $display("RESULT: FAIL");
            $fatal(1, "retire mismatch");
        end
    endtask

    task automatic check_idle(input string name, input logic act);
        if (act !== 1'b0) begin
            $display("[FAIL] %s expected 0 actual %b", name, act);
            $display("RESULT: FAIL");
            $fatal(1, "retire port active with nothing outstanding");
        end
    endtask

    task automatic build_table();
        // sources for the alu group: x1 = 5, x2 = -3
        add_row("addi_pos", i_type(12'h005, 0, 3'b000, 1), RND, 1'b1, 1, 32'h0000_0005);
        add_row("addi_neg", i_type(12'hffd, 0, 3'b000, 2), RND, 1'b1, 2, 32'hffff_fffd);
        add_row("add", r_type(7'h00, 2, 1, 3'b000, 3), RND, 1'b1, 3, 32'h0000_0002);
        add_row("sub_wrap", r_type(7'h20, 1, 0, 3'b000, 4), RND, 1'b1, 4, 32'hffff_fffb);
        add_row("sra_neg", r_type(7'h20, 1, 2, 3'b101, 5), RND, 1'b1, 5, 32'hffff_ffff);
        add_row("srl_neg", r_type(7'h00, 1, 2, 3'b101, 6), RND, 1'b1, 6, 32'h07ff_ffff);
        add_row("slt_mixed", r_type(7'h00, 1, 2, 3'b010, 7), RND, 1'b1, 7, 32'h0000_0001);
        add_row("sltu_mixed", r_type(7'h00, 1, 2, 3'b011, 8), RND, 1'b1, 8, 32'h0000_0000);
        add_row("sll", r_type(7'h00, 1, 1, 3'b001, 9), RND, 1'b1, 9, 32'h0000_00a0);
        add_row("xor", r_type(7'h00, 2, 1, 3'b100, 10), RND, 1'b1, 10, 32'hffff_fff8);
        add_row("slti", i_type(12'hffe, 2, 3'b010, 13), RND, 1'b1, 13, 32'h0000_0001);
        add_row("sltiu", i_type(12'hfff, 1, 3'b011, 14), RND, 1'b1, 14, 32'h0000_0001);
        add_row("ori", i_type(12'hf00, 0, 3'b110, 16), RND, 1'b1, 16, 32'hffff_ff00);
        add_row("andi", i_type(12'h7ff, 16, 3'b111, 17), RND, 1'b1, 17, 32'h0000_0700);
        add_row("slli", i_type(12'h01c, 1, 3'b001, 18), RND, 1'b1, 18, 32'h5000_0000);
        add_row("srai", i_type(12'h404, 16, 3'b101, 19), RND, 1'b1, 19, 32'hffff_fff0);
        add_row("lui", u_type(20'h12345, 21), RND, 1'b1, 21, 32'h1234_5000);
        add_row("lui_addi", i_type(12'h678, 21, 3'b000, 21), 0, 1'b1, 21, 32'h1234_5678);
        add_row("lui_neg", u_type(20'hdeadc, 22), RND, 1'b1, 22, 32'hdead_c000);
        add_row("lui_addi_neg", i_type(12'heef, 22, 3'b000, 22), 0, 1'b1, 22, 32'hdead_beef);
        // dependent chain back to back, then the same chain with a gap
        add_row("fwd_rs1", i_type(12'h00a, 1, 3'b000, 23), RND, 1'b1, 23, 32'h0000_000f);
        add_row("fwd_both", r_type(7'h00, 23, 23, 3'b000, 24), 0, 1'b1, 24, 32'h0000_001e);
        add_row("fwd_rs2", r_type(7'h20, 24, 1, 3'b000, 25), 0, 1'b1, 25, 32'hffff_ffe7);
        add_row("gap_rs1", i_type(12'h00a, 1, 3'b000, 27), 1, 1'b1, 27, 32'h0000_000f);
        add_row("gap_both", r_type(7'h00, 27, 27, 3'b000, 28), 1, 1'b1, 28, 32'h0000_001e);
        add_row("gap_rs2", r_type(7'h20, 28, 1, 3'b000, 29), 1, 1'b1, 29, 32'hffff_ffe7);
        add_row("x0_write", i_type(12'h007, 1, 3'b000, 0), RND, 1'b1, 0, 32'h0000_000c);
        add_row("x0_read", r_type(7'h00, 1, 0, 3'b000, 31), 0, 1'b1, 31, 32'h0000_0005);
        // rejected words name x1..x3 as rd, which must keep their values
        add_row("ill_load", {12'h000, 5'd0, 3'b010, 5'd1, 7'b0000011}, RND, 1'b0, 1, '0);
        add_row("ill_srli", i_type(12'h021, 1, 3'b101, 2), RND, 1'b0, 2, '0);
        add_row("ill_funct7", r_type(7'h01, 2, 1, 3'b000, 3), RND, 1'b0, 3, '0);
        add_row("after_ill", r_type(7'h00, 1, 3, 3'b000, 31), 0, 1'b1, 31, 32'h0000_0007);
        add_row("after_ill_x2", r_type(7'h00, 2, 1, 3'b000, 30), RND, 1'b1, 30, 32'h0000_0002);
    endtask

    initial begin
        int gap;
        gap = $urandom(32'heccf_5f30);
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        build_table();
        repeat (8) @(posedge clk);
        #1 reset_i = 1'b0;
        repeat (3) begin  // a few idle cycles after reset
            @(posedge clk);
            #1;
        end
        for (int i = 0; i < row_inst.size(); i++) begin
            gap = (row_gap[i] < 0) ? int'($urandom_range(2, 0)) : row_gap[i];
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            inst_valid_i = 1'b1;
            inst_i       = row_inst[i];
            pending.push_back(i);
            @(posedge clk);
            #1;
            inst_valid_i = 1'b0;
            inst_i       = '0;
        end
        repeat (4) @(posedge clk);  // two-cycle latency plus margin
        if (pending.size() != 0) begin
            $display("%0d instructions never retired", pending.size());
            $display("RESULT: FAIL");
            $fatal(1, "missing retires");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

    // sample retires mid-cycle, away from the driving edge
    initial begin
        riscv151_pkg::retire_t seen;
        int idx;
        forever begin
            @(negedge clk);
            seen.valid   = retire_valid_o;
            seen.illegal = retire_illegal_o;
            seen.rd      = retire_rd_o;
            seen.data    = retire_data_o;
            if (pending.size() == 0) begin
                check_idle(reset_i ? "reset_valid" : "idle_valid", retire_valid_o);
                check_idle(reset_i ? "reset_illegal" : "idle_illegal", retire_illegal_o);
            end else if (retire_valid_o || retire_illegal_o) begin
                idx = pending.pop_front();
                check_retire(row_name[idx], row_exp[idx], seen);
            end
        end
    end

    initial begin
        #1;  // table is filled at time zero
        repeat (row_inst.size() * 4 + 50) @(posedge clk);
        $display("timeout: the instruction table did not finish in time");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
src/riscv151_pkg.sv
src/inst_decode.sv
src/regfile_1w2r.sv
src/pipe_reg.sv
src/alu_exec.sv
src/riscv151.sv
verification/riscv151_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, then search the log for the result line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f src.f --top-module riscv151_tb \
    -o riscv151_sim > build.log 2>&1 \
    && ./obj_dir/riscv151_sim > sim.log 2>&1 \
    || echo "build or simulation exited with an error, see build.log and sim.log"

cat sim.log 2>/dev/null
grep -qx "RESULT: PASS" sim.log && exit 0 || exit 1
